/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int reg_addr_w = 5;   // x0..x31
    localparam int csr_addr_w = 12;
    localparam int xlen       = 32;

    // major opcode, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_imm    = 7'b0010011,   // alu with immediate
        op_reg    = 7'b0110011,   // alu reg-reg
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_system = 7'b1110011    // csr access, ecall, ebreak, mret
    } opcode_e;

endpackage

/* hw/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    // source of one EX operand
    typedef enum logic [1:0] {
        fwd_none = 2'd0,   // register file read
        fwd_mem  = 2'd1,   // result sitting in MEM
        fwd_wb   = 2'd2    // result sitting in WB
    } fwd_sel_e;

    // pipeline registers, also the bit index in the 4-bit stall and flush vectors
    typedef enum logic [1:0] {
        stage_if_id  = 2'd0,
        stage_id_ex  = 2'd1,
        stage_ex_mem = 2'd2,
        stage_mem_wb = 2'd3
    } stage_e;

endpackage

/* hw/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit
    import rv_isa_pkg::*, pipe_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    // ID stage
    input  logic [reg_addr_w-1:0] id_rs1,
    input  logic [reg_addr_w-1:0] id_rs2,

    // EX stage
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic [reg_addr_w-1:0] ex_rs1,
    input  logic [reg_addr_w-1:0] ex_rs2,
    input  opcode_e               ex_opcode,
    input  logic [csr_addr_w-1:0] ex_csr_addr,
    input  logic                  ex_jump,

    // MEM stage
    input  logic [reg_addr_w-1:0] mem_rd,
    input  logic                  mem_reg_we,
    input  logic                  mem_csr_we,
    input  logic [csr_addr_w-1:0] mem_csr_addr,

    // WB stage
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic                  wb_reg_we,
    input  logic                  wb_csr_we,
    input  logic [csr_addr_w-1:0] wb_csr_addr,

    input  logic                  branch_miss,
    input  logic                  trap_done,
    input  logic                  csr_ready,
    input  logic                  standby_mode,
    input  logic                  replay_flush,

    output fwd_sel_e              fwd_rs1,
    output fwd_sel_e              fwd_rs2,
    output logic                  csr_hit_mem,
    output logic                  csr_hit_wb,

    output logic                  if_id_stall,
    output logic                  id_ex_stall,
    output logic                  ex_mem_stall,
    output logic                  mem_wb_stall,
    output logic                  if_id_flush,
    output logic                  id_ex_flush,
    output logic                  ex_mem_flush,
    output logic                  mem_wb_flush
);

    logic load_use;
    logic mem_hit_rs1, mem_hit_rs2;
    logic wb_hit_rs1, wb_hit_rs2;
    logic standby_q;       // standby_mode one cycle ago
    logic standby_entry;   // one-cycle pulse after standby rises

    // load result not ready until MEM, so ID must wait a cycle
    assign load_use = (ex_opcode == op_load) && (ex_rd != '0)
                      && ((ex_rd == id_rs1) || (ex_rd == id_rs2));

    // x0 writes never forward
    assign mem_hit_rs1 = mem_reg_we && (mem_rd != '0) && (mem_rd == ex_rs1);
    assign mem_hit_rs2 = mem_reg_we && (mem_rd != '0) && (mem_rd == ex_rs2);
    assign wb_hit_rs1  = wb_reg_we && (wb_rd != '0) && (wb_rd == ex_rs1);
    assign wb_hit_rs2  = wb_reg_we && (wb_rd != '0) && (wb_rd == ex_rs2);

    // MEM holds the younger write, so it wins
    assign fwd_rs1 = mem_hit_rs1 ? fwd_mem : (wb_hit_rs1 ? fwd_wb : fwd_none);
    assign fwd_rs2 = mem_hit_rs2 ? fwd_mem : (wb_hit_rs2 ? fwd_wb : fwd_none);

    // both reported, priority resolved in operand_forward
    assign csr_hit_mem = mem_csr_we && (mem_csr_addr == ex_csr_addr);
    assign csr_hit_wb  = wb_csr_we && (wb_csr_addr == ex_csr_addr);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            standby_q     <= 1'b0;
            standby_entry <= 1'b0;
        end else begin
            standby_q     <= standby_mode;
            standby_entry <= standby_mode && !standby_q;
        end
    end

    // later rules override the stalls of earlier ones, flushes accumulate
    always_comb begin
        if_id_stall  = 1'b0;
        id_ex_stall  = 1'b0;
        ex_mem_stall = 1'b0;
        mem_wb_stall = 1'b0;
        if_id_flush  = 1'b0;
        id_ex_flush  = 1'b0;
        ex_mem_flush = 1'b0;
        mem_wb_flush = 1'b0;   // never requested by this unit

        if (load_use) begin
            if_id_stall  = 1'b1;
            id_ex_stall  = 1'b1;
            ex_mem_stall = 1'b1;
            mem_wb_stall = 1'b1;
            id_ex_flush  = 1'b1;   // bubble into EX
        end

        if (trap_done && (branch_miss || ex_jump)) begin
            if_id_flush = 1'b1;
            id_ex_flush = 1'b1;
        end

        if (replay_flush) begin
            if_id_flush  = 1'b1;
            id_ex_flush  = 1'b1;
            ex_mem_flush = 1'b1;
        end

        if (standby_mode) begin
            // front end held, back end drains
            if_id_stall  = 1'b1;
            id_ex_stall  = 1'b1;
            ex_mem_stall = 1'b0;
            mem_wb_stall = 1'b0;
            if (standby_entry)
                id_ex_flush = 1'b1;   // squash the faulting ID instruction
        end else if (!trap_done || !csr_ready) begin
            if_id_stall  = 1'b1;
            id_ex_stall  = 1'b1;
            ex_mem_stall = 1'b1;
            mem_wb_stall = 1'b1;
        end
    end

endmodule

/* hw/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward
    import rv_isa_pkg::*, pipe_ctrl_pkg::*;
(
    input  fwd_sel_e            fwd_rs1,
    input  fwd_sel_e            fwd_rs2,
    input  logic                csr_hit_mem,
    input  logic                csr_hit_wb,

    input  logic [xlen-1:0]     rf_rs1_data,
    input  logic [xlen-1:0]     rf_rs2_data,
    input  logic [xlen-1:0]     mem_result,
    input  logic [xlen-1:0]     wb_result,

    input  logic [xlen-1:0]     csr_rdata,       // from the CSR file
    input  logic [xlen-1:0]     mem_csr_wdata,
    input  logic [xlen-1:0]     wb_csr_wdata,

    output logic [xlen-1:0]     ex_op1,
    output logic [xlen-1:0]     ex_op2,
    output logic [xlen-1:0]     ex_csr_value
);

    // one operand mux, shared by rs1 and rs2
    function automatic logic [xlen-1:0] pick_operand(
        input fwd_sel_e        sel,
        input logic [xlen-1:0] rf_word,
        input logic [xlen-1:0] mem_word,
        input logic [xlen-1:0] wb_word
    );
        logic [xlen-1:0] word;
        case (sel)
            fwd_mem: word = mem_word;
            fwd_wb:  word = wb_word;
            default: word = rf_word;   // fwd_none and the unused code
        endcase
        return word;
    endfunction

    always_comb begin
        ex_op1 = pick_operand(fwd_rs1, rf_rs1_data, mem_result, wb_result);
        ex_op2 = pick_operand(fwd_rs2, rf_rs2_data, mem_result, wb_result);
    end

    // MEM write is younger than WB write
    always_comb begin
        if (csr_hit_mem)
            ex_csr_value = mem_csr_wdata;
        else if (csr_hit_wb)
            ex_csr_value = wb_csr_wdata;
        else
            ex_csr_value = csr_rdata;
    end

endmodule

/* hw/pipe_control.sv */
`timescale 1ns/1ps

module pipe_control
    import rv_isa_pkg::*, pipe_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic [reg_addr_w-1:0] id_rs1,
    input  logic [reg_addr_w-1:0] id_rs2,

    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic [reg_addr_w-1:0] ex_rs1,
    input  logic [reg_addr_w-1:0] ex_rs2,
    input  opcode_e               ex_opcode,
    input  logic [csr_addr_w-1:0] ex_csr_addr,
    input  logic                  ex_jump,

    input  logic [reg_addr_w-1:0] mem_rd,
    input  logic                  mem_reg_we,
    input  logic                  mem_csr_we,
    input  logic [csr_addr_w-1:0] mem_csr_addr,

    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic                  wb_reg_we,
    input  logic                  wb_csr_we,
    input  logic [csr_addr_w-1:0] wb_csr_addr,

    input  logic                  branch_miss,
    input  logic                  trap_done,
    input  logic                  csr_ready,
    input  logic                  standby_mode,
    input  logic                  replay_flush,

    input  logic [xlen-1:0]       rf_rs1_data,
    input  logic [xlen-1:0]       rf_rs2_data,
    input  logic [xlen-1:0]       mem_result,
    input  logic [xlen-1:0]       wb_result,
    input  logic [xlen-1:0]       csr_rdata,
    input  logic [xlen-1:0]       mem_csr_wdata,
    input  logic [xlen-1:0]       wb_csr_wdata,

    output logic                  if_id_stall,
    output logic                  id_ex_stall,
    output logic                  ex_mem_stall,
    output logic                  mem_wb_stall,
    output logic                  if_id_flush,
    output logic                  id_ex_flush,
    output logic                  ex_mem_flush,
    output logic                  mem_wb_flush,

    output fwd_sel_e              fwd_rs1,
    output fwd_sel_e              fwd_rs2,
    output logic [xlen-1:0]       ex_op1,
    output logic [xlen-1:0]       ex_op2,
    output logic [xlen-1:0]       ex_csr_value
);

    logic csr_hit_mem;
    logic csr_hit_wb;

    hazard_unit u_hazard (
        .clk          (clk),
        .reset        (reset),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .ex_rd        (ex_rd),
        .ex_rs1       (ex_rs1),
        .ex_rs2       (ex_rs2),
        .ex_opcode    (ex_opcode),
        .ex_csr_addr  (ex_csr_addr),
        .ex_jump      (ex_jump),
        .mem_rd       (mem_rd),
        .mem_reg_we   (mem_reg_we),
        .mem_csr_we   (mem_csr_we),
        .mem_csr_addr (mem_csr_addr),
        .wb_rd        (wb_rd),
        .wb_reg_we    (wb_reg_we),
        .wb_csr_we    (wb_csr_we),
        .wb_csr_addr  (wb_csr_addr),
        .branch_miss  (branch_miss),
        .trap_done    (trap_done),
        .csr_ready    (csr_ready),
        .standby_mode (standby_mode),
        .replay_flush (replay_flush),
        .fwd_rs1      (fwd_rs1),
        .fwd_rs2      (fwd_rs2),
        .csr_hit_mem  (csr_hit_mem),
        .csr_hit_wb   (csr_hit_wb),
        .if_id_stall  (if_id_stall),
        .id_ex_stall  (id_ex_stall),
        .ex_mem_stall (ex_mem_stall),
        .mem_wb_stall (mem_wb_stall),
        .if_id_flush  (if_id_flush),
        .id_ex_flush  (id_ex_flush),
        .ex_mem_flush (ex_mem_flush),
        .mem_wb_flush (mem_wb_flush)
    );

    // selects also leave the top for observation
    operand_forward u_forward (
        .fwd_rs1       (fwd_rs1),
        .fwd_rs2       (fwd_rs2),
        .csr_hit_mem   (csr_hit_mem),
        .csr_hit_wb    (csr_hit_wb),
        .rf_rs1_data   (rf_rs1_data),
        .rf_rs2_data   (rf_rs2_data),
        .mem_result    (mem_result),
        .wb_result     (wb_result),
        .csr_rdata     (csr_rdata),
        .mem_csr_wdata (mem_csr_wdata),
        .wb_csr_wdata  (wb_csr_wdata),
        .ex_op1        (ex_op1),
        .ex_op2        (ex_op2),
        .ex_csr_value  (ex_csr_value)
    );

endmodule

/* sim/pipe_control_chk.sv */
`timescale 1ns/1ps

module pipe_control_chk
    import rv_isa_pkg::*, pipe_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [reg_addr_w-1:0] id_rs1,
    input  logic [reg_addr_w-1:0] id_rs2,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  opcode_e               ex_opcode,
    input  logic                  standby_mode,
    input  logic                  if_id_stall,
    input  logic                  id_ex_stall,
    input  logic                  ex_mem_stall,
    input  logic                  mem_wb_stall,
    input  logic                  id_ex_flush
);

    logic       load_use_seen;
    logic [3:0] stall_vec;   // indexed by stage_e

    assign load_use_seen = (ex_opcode == op_load) && (ex_rd != '0)
                           && ((ex_rd == id_rs1) || (ex_rd == id_rs2));
    assign stall_vec = {mem_wb_stall, ex_mem_stall, id_ex_stall, if_id_stall};

    // bubble must follow a load-use stall
    a_load_use_flush: assert property (@(posedge clk) disable iff (reset)
        load_use_seen |-> id_ex_flush)
        else $error("load-use hazard without id_ex flush");

    a_standby_drain: assert property (@(posedge clk) disable iff (reset)
        standby_mode |-> !stall_vec[stage_ex_mem] && !stall_vec[stage_mem_wb])
        else $error("back end stalled during standby");

    a_reset_no_stall: assert property (@(posedge clk)
        reset |-> stall_vec == 4'b0000)
        else $error("stall requested while in reset");

endmodule

bind hazard_unit pipe_control_chk u_chk (
    .clk          (clk),
    .reset        (reset),
    .id_rs1       (id_rs1),
    .id_rs2       (id_rs2),
    .ex_rd        (ex_rd),
    .ex_opcode    (ex_opcode),
    .standby_mode (standby_mode),
    .if_id_stall  (if_id_stall),
    .id_ex_stall  (id_ex_stall),
    .ex_mem_stall (ex_mem_stall),
    .mem_wb_stall (mem_wb_stall),
    .id_ex_flush  (id_ex_flush)
);

/* sim/pipe_control_tb.sv */
`timescale 1ns/1ps

module pipe_control_tb
    import rv_isa_pkg::*, pipe_ctrl_pkg::*;
();

    localparam int    reset_cycles = 5;
    localparam int    max_vectors  = 64;
    localparam int    cycle_limit  = reset_cycles + 2 * max_vectors + 20;
    localparam string vec_path     = "sim/pipe_control_vectors.txt";

    logic                  clk, reset;
    logic [reg_addr_w-1:0] id_rs1, id_rs2, ex_rd, ex_rs1, ex_rs2, mem_rd, wb_rd;
    opcode_e               ex_opcode;
    logic [csr_addr_w-1:0] ex_csr_addr, mem_csr_addr, wb_csr_addr;
    logic                  ex_jump, mem_reg_we, mem_csr_we, wb_reg_we, wb_csr_we;
    logic                  branch_miss, trap_done, csr_ready, standby_mode, replay_flush;
    logic [xlen-1:0]       rf_rs1_data, rf_rs2_data, mem_result, wb_result;
    logic [xlen-1:0]       csr_rdata, mem_csr_wdata, wb_csr_wdata;
    logic                  if_id_stall, id_ex_stall, ex_mem_stall, mem_wb_stall;
    logic                  if_id_flush, id_ex_flush, ex_mem_flush, mem_wb_flush;
    fwd_sel_e              fwd_rs1, fwd_rs2;
    logic [xlen-1:0]       ex_op1, ex_op2, ex_csr_value;
    int unsigned           cycles;

    pipe_control u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit, well above the length of the vector replay
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: vector replay still running after %0d cycles", cycle_limit);
        $display("Test failures found");
        $fatal(1, "simulation timed out");
    end

    task automatic check_ctrl(input string test, input string what,
                              input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %b, actual %b", test, what, exp, act);
            $display("Test failures found");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic check_fwd(input string test, input string what,
                             input fwd_sel_e exp, input fwd_sel_e act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %s (%0d), actual %s (%0d)",
                     test, what, exp.name(), exp, act.name(), act);
            $display("Test failures found");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic check_word(input string test, input string what,
                              input logic [xlen-1:0] exp, input logic [xlen-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", test, what, exp, act);
            $display("Test failures found");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    // quiet pipeline, no hazard and nothing waiting
    task automatic drive_idle_inputs();
        {id_rs1, id_rs2, ex_rd, ex_rs1, ex_rs2, mem_rd, wb_rd} = '0;
        ex_opcode = op_imm;
        {ex_csr_addr, mem_csr_addr, wb_csr_addr} = '0;
        {mem_reg_we, mem_csr_we, wb_reg_we, wb_csr_we} = 4'b0000;
        {ex_jump, branch_miss, trap_done, csr_ready, standby_mode, replay_flush} = 6'b001100;
        {rf_rs1_data, rf_rs2_data, mem_result, wb_result} = '0;
        {csr_rdata, mem_csr_wdata, wb_csr_wdata} = '0;
    endtask

    task automatic run_vector(input string line);
        logic [8*24-1:0]       v_name;
        logic [reg_addr_w-1:0] v_id1, v_id2, v_exrd, v_exrs1, v_exrs2, v_memrd, v_wbrd;
        logic [6:0]            v_op;
        logic [csr_addr_w-1:0] v_excsr, v_memcsr, v_wbcsr;
        logic [3:0]            v_we, e_stall, e_flush, act_stall, act_flush;
        logic [5:0]            v_ctrl;
        logic [xlen-1:0]       v_rf1, v_rf2, v_mres, v_wres, v_csr, v_mcsr, v_wcsr;
        logic [xlen-1:0]       e_op1, e_op2, e_csr;
        logic [1:0]            e_fwd1, e_fwd2;
        int                    n;
        string                 tname;

        n = $sscanf(line,
            "%s %h %h %h %h %h %h %h %h %h %h %h %b %b %h %h %h %h %h %h %h %b %b %h %h %h %h %h",
            v_name, v_id1, v_id2, v_exrd, v_exrs1, v_exrs2, v_memrd, v_wbrd,
            v_op, v_excsr, v_memcsr, v_wbcsr, v_we, v_ctrl,
            v_rf1, v_rf2, v_mres, v_wres, v_csr, v_mcsr, v_wcsr,
            e_stall, e_flush, e_fwd1, e_fwd2, e_op1, e_op2, e_csr);
        if (n != 28) begin
            $display("vector line has %0d readable columns instead of 28: %s", n, line);
            $display("Test failures found");
            $fatal(1, "bad vector line");
        end
        tname = $sformatf("%0s", v_name);

        @(negedge clk);
        {id_rs1, id_rs2, ex_rd, ex_rs1, ex_rs2} = {v_id1, v_id2, v_exrd, v_exrs1, v_exrs2};
        mem_rd       = v_memrd;
        wb_rd        = v_wbrd;
        ex_opcode    = opcode_e'(v_op);
        ex_csr_addr  = v_excsr;
        mem_csr_addr = v_memcsr;
        wb_csr_addr  = v_wbcsr;
        {mem_reg_we, mem_csr_we, wb_reg_we, wb_csr_we} = v_we;
        {ex_jump, branch_miss, trap_done, csr_ready, standby_mode, replay_flush} = v_ctrl;
        {rf_rs1_data, rf_rs2_data, mem_result, wb_result} = {v_rf1, v_rf2, v_mres, v_wres};
        {csr_rdata, mem_csr_wdata, wb_csr_wdata} = {v_csr, v_mcsr, v_wcsr};

        #1;   // 1 ns before the rising edge
        act_stall[stage_if_id]  = if_id_stall;
        act_stall[stage_id_ex]  = id_ex_stall;
        act_stall[stage_ex_mem] = ex_mem_stall;
        act_stall[stage_mem_wb] = mem_wb_stall;
        act_flush[stage_if_id]  = if_id_flush;
        act_flush[stage_id_ex]  = id_ex_flush;
        act_flush[stage_ex_mem] = ex_mem_flush;
        act_flush[stage_mem_wb] = mem_wb_flush;

        check_ctrl(tname, "stall", e_stall, act_stall);
        check_ctrl(tname, "flush", e_flush, act_flush);
        check_fwd(tname, "fwd_rs1", fwd_sel_e'(e_fwd1), fwd_rs1);
        check_fwd(tname, "fwd_rs2", fwd_sel_e'(e_fwd2), fwd_rs2);
        check_word(tname, "ex_op1", e_op1, ex_op1);
        check_word(tname, "ex_op2", e_op2, ex_op2);
        check_word(tname, "ex_csr_value", e_csr, ex_csr_value);
    endtask

    initial begin
        int    fd;
        int    code;
        int    n_vectors;
        string line;

        reset = 1'b1;
        drive_idle_inputs();
        n_vectors = 0;
        fd = $fopen(vec_path, "r");
        if (fd == 0) begin
            $display("cannot open vector file %s", vec_path);
            $display("Test failures found");
            $fatal(1, "missing vector file");
        end

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // skip comment and blank lines
            if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
                n_vectors++;
                if (n_vectors > max_vectors) begin
                    $display("vector file holds more than %0d tests", max_vectors);
                    $display("Test failures found");
                    $fatal(1, "too many vectors");
                end
                run_vector(line);
            end
        end
        $fclose(fd);

        if (n_vectors == 0) begin
            $display("no test vectors found in %s", vec_path);
            $display("Test failures found");
            $fatal(1, "empty vector file");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

/* vlog.f */
hw/rv_isa_pkg.sv
hw/pipe_ctrl_pkg.sv
hw/hazard_unit.sv
hw/operand_forward.sv
hw/pipe_control.sv
sim/pipe_control_chk.sv
sim/pipe_control_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it, exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module pipe_control_tb \
    -Mdir obj_dir -o sim_pipe_control

./obj_dir/sim_pipe_control

/* sim/pipe_control_vectors.txt */
# name id_rs1 id_rs2 ex_rd ex_rs1 ex_rs2 mem_rd wb_rd opcode ex_csr mem_csr wb_csr
#   we(mem_reg mem_csr wb_reg wb_csr) ctrl(jump branch trap_done csr_ready standby replay)
#   rf1 rf2 mem_res wb_res csr_rdata mem_csr_wd wb_csr_wd, then expected stall flush
#   (bit 0 = if_id) fwd_rs1 fwd_rs2 ex_op1 ex_op2 ex_csr_value
idle          00 00 00 00 00 00 00 13 000 000 000 0000 001100 a1 a2 c0 d0 e0 e1 e2 0000 0000 0 0 a1 a2 e0
fwd_mem_rs1   00 00 00 05 00 05 00 33 000 000 000 1000 001100 a1 a2 c0 d0 e0 e1 e2 0000 0000 1 0 c0 a2 e0
fwd_wb_rs2    00 00 00 00 06 00 06 33 000 000 000 0010 001100 a1 a2 c0 d0 e0 e1 e2 0000 0000 0 2 a1 d0 e0
mem_over_wb   00 00 00 07 07 07 07 33 000 000 000 1010 001100 a1 a2 c0 d0 e0 e1 e2 0000 0000 1 1 c0 c0 e0
fwd_split     00 00 00 0a 0b 0b 0a 33 000 000 000 1010 001100 a1 a2 c0 d0 e0 e1 e2 0000 0000 2 1 d0 c0 e0
x0_no_fwd     00 00 00 00 00 00 00 33 000 000 000 1010 001100 a1 a2 c0 d0 e0 e1 e2 0000 0000 0 0 a1 a2 e0
we_off        00 00 00 08 08 08 08 33 000 000 000 0000 001100 a1 a2 c0 d0 e0 e1 e2 0000 0000 0 0 a1 a2 e0
load_use_rs2  01 09 09 00 00 00 00 03 000 000 000 0000 001100 a1 a2 c0 d0 e0 e1 e2 1111 0010 0 0 a1 a2 e0
load_rd_zero  00 00 00 00 00 00 00 03 000 000 000 0000 001100 a1 a2 c0 d0 e0 e1 e2 0000 0000 0 0 a1 a2 e0
alu_no_stall  01 09 09 00 00 00 00 33 000 000 000 0000 001100 a1 a2 c0 d0 e0 e1 e2 0000 0000 0 0 a1 a2 e0
branch_miss   00 00 00 00 00 00 00 63 000 000 000 0000 011100 a1 a2 c0 d0 e0 e1 e2 0000 0011 0 0 a1 a2 e0
jump          00 00 00 00 00 00 00 6f 000 000 000 0000 101100 a1 a2 c0 d0 e0 e1 e2 0000 0011 0 0 a1 a2 e0
branch_trap   00 00 00 00 00 00 00 63 000 000 000 0000 010100 a1 a2 c0 d0 e0 e1 e2 1111 0000 0 0 a1 a2 e0
replay        00 00 00 00 00 00 00 13 000 000 000 0000 001101 a1 a2 c0 d0 e0 e1 e2 0000 0111 0 0 a1 a2 e0
branch_replay 00 00 00 00 00 00 00 63 000 000 000 0000 011101 a1 a2 c0 d0 e0 e1 e2 0000 0111 0 0 a1 a2 e0
trap_wait     00 00 00 00 00 00 00 13 000 000 000 0000 000100 a1 a2 c0 d0 e0 e1 e2 1111 0000 0 0 a1 a2 e0
csr_wait      00 00 00 00 00 00 00 73 000 000 000 0000 001000 a1 a2 c0 d0 e0 e1 e2 1111 0000 0 0 a1 a2 e0
standby_rise  00 00 00 00 00 00 00 13 000 000 000 0000 001110 a1 a2 c0 d0 e0 e1 e2 0011 0000 0 0 a1 a2 e0
standby_entry 00 00 00 00 00 00 00 13 000 000 000 0000 001110 a1 a2 c0 d0 e0 e1 e2 0011 0010 0 0 a1 a2 e0
standby_trap  00 00 00 00 00 00 00 13 000 000 000 0000 000110 a1 a2 c0 d0 e0 e1 e2 0011 0000 0 0 a1 a2 e0
csr_mem_wb    00 00 00 00 00 00 00 73 300 300 300 0101 001100 a1 a2 c0 d0 e0 e1 e2 0000 0000 0 0 a1 a2 e1
csr_wb_only   00 00 00 00 00 00 00 73 341 300 341 0101 001100 a1 a2 c0 d0 e0 e1 e2 0000 0000 0 0 a1 a2 e2
csr_no_match  00 00 00 00 00 00 00 73 305 300 341 0101 001100 a1 a2 c0 d0 e0 e1 e2 0000 0000 0 0 a1 a2 e0
